//--- verilog/ble_rx_pkg.sv
// receiver types assume UART 8N1 framing and a receive FIFO of no more than 64 words.
package ble_rx_pkg;

	// cycles per data bit, also reused for gap lengths in bit times.
	typedef logic [9:0] bit_cycles_t;

	// one received byte and the receiver's frame state.
	typedef struct packed {
		logic [7:0] data;
		logic       valid;
		logic       collecting;
	} rx_byte_t;

	// earlier byte sits in the upper half.
	typedef logic [15:0] rfifo_word_t;

	typedef struct packed {
		logic [7:0] wr_count;
		logic [6:0] rd_count;
		logic       full;
		logic       empty;
	} rfifo_status_t;

	// app command codes.
	localparam logic [7:0] CMD_SELECT = 8'h53;
	localparam logic [7:0] CMD_GO     = 8'h47;
	localparam logic [7:0] CMD_HALT   = 8'h48;

	// low half filler for an odd reply.
	localparam logic [7:0] PAD_BYTE = 8'h00;

endpackage

//--- verilog/uart_rx.sv
// 8N1 only; cycles_per_databit must be at least 4 and held steady while a frame is received.
`timescale 1ns/1ns

module uart_rx import ble_rx_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        rx_line,
	input  bit_cycles_t cycles_per_databit,
	output rx_byte_t    rx_byte
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} state_t;

	state_t      state;
	logic        line_meta;
	logic        line_sync;
	logic        line_prev;
	bit_cycles_t cycle_count;
	logic [2:0]  bit_index;
	logic [7:0]  shift_reg;
	logic [7:0]  data_q;
	logic        valid_q;
	logic        collecting_q;
	logic        start_edge;
	logic        half_bit;
	logic        bit_end;

	// two-flop synchronizer, idles high like the line.
	always_ff @(posedge clock) begin
		if (reset) begin
			line_meta <= 1'b1;
			line_sync <= 1'b1;
			line_prev <= 1'b1;
		end else begin
			line_meta <= rx_line;
			line_sync <= line_meta;
			line_prev <= line_sync;
		end
	end

	assign start_edge = line_prev & ~line_sync;
	assign half_bit   = (cycle_count == (cycles_per_databit >> 1) - 1'b1);
	assign bit_end    = (cycle_count == cycles_per_databit - 1'b1);

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= S_IDLE;
			cycle_count  <= '0;
			bit_index    <= '0;
			valid_q      <= 1'b0;
			collecting_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				S_IDLE: begin
					cycle_count <= '0;
					if (start_edge) begin
						state        <= S_START;
						collecting_q <= 1'b1;
					end
				end
				S_START: begin
					if (half_bit) begin
						cycle_count <= '0;
						bit_index   <= '0;
						// line back high by mid start bit, so only a glitch.
						if (line_sync) begin
							state        <= S_IDLE;
							collecting_q <= 1'b0;
						end else begin
							state <= S_DATA;
						end
					end else begin
						cycle_count <= cycle_count + 1'b1;
					end
				end
				S_DATA: begin
					if (bit_end) begin
						cycle_count <= '0;
						bit_index   <= bit_index + 1'b1;
						if (bit_index == 3'd7)
							state <= S_STOP;
					end else begin
						cycle_count <= cycle_count + 1'b1;
					end
				end
				S_STOP: begin
					if (bit_end) begin
						state        <= S_IDLE;
						collecting_q <= 1'b0;
						// low stop bit drops the byte.
						valid_q      <= line_sync;
					end else begin
						cycle_count <= cycle_count + 1'b1;
					end
				end
			endcase
		end
	end

	// data bits arrive lsb first.
	always_ff @(posedge clock) begin
		if (state == S_DATA && bit_end)
			shift_reg <= {line_sync, shift_reg[7:1]};
		if (state == S_STOP && bit_end)
			data_q <= shift_reg;
	end

	assign rx_byte = '{data: data_q, valid: valid_q, collecting: collecting_q};

	// a byte is only presented once its frame has closed.
	assert property (@(posedge clock) disable iff (reset)
		rx_byte.valid |-> !rx_byte.collecting);

endmodule

//--- verilog/rx_fifo.sv
// DEPTH_WORDS must be a power of two up to 64; bytes written while full are lost.
`timescale 1ns/1ns

module rx_fifo import ble_rx_pkg::*; #(
	parameter int DEPTH_WORDS = 64
) (
	input  logic          clock,
	input  logic          reset,
	input  logic [7:0]    wr_byte,
	input  logic          wr_en,
	input  logic          rd_en,
	output rfifo_word_t   rd_word,
	output rfifo_status_t status
);

	localparam int DEPTH_BYTES = DEPTH_WORDS * 2;
	localparam int AW = $clog2(DEPTH_BYTES);

	logic [7:0]    mem [DEPTH_BYTES];
	logic [AW:0]   wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] rd_base;
	logic [AW:0]   byte_count;
	logic [AW-1:0] word_count;
	logic          full;
	logic          empty;
	logic          wr_ok;
	logic          rd_ok;

	// write pointer counts bytes, read pointer counts words; both carry a wrap bit.
	assign byte_count = wr_ptr - {rd_ptr, 1'b0};
	assign word_count = byte_count[AW:1];
	assign full       = (byte_count == DEPTH_BYTES);
	// empty means no whole word to read.
	assign empty      = (word_count == '0);

	assign wr_ok   = wr_en & ~full;
	assign rd_ok   = rd_en & ~empty;
	assign rd_base = {rd_ptr[AW-2:0], 1'b0};

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_ok)
			mem[wr_ptr[AW-1:0]] <= wr_byte;
		// earlier byte goes high.
		if (rd_ok)
			rd_word <= {mem[rd_base], mem[rd_base | 1'b1]};
	end

	assign status = '{
		wr_count: 8'(byte_count),
		rd_count: 7'(word_count),
		full:     full,
		empty:    empty
	};

	// a read pointer overtaking the write pointer shows up as a wrapped count.
	assert property (@(posedge clock) disable iff (reset)
		byte_count <= DEPTH_BYTES);

endmodule

//--- verilog/handle_at_response.sv
// one reply per arming; the reply end is found by line idle time only, the timer starts at the first byte.
`timescale 1ns/1ns

module handle_at_response import ble_rx_pkg::*; #(
	parameter int DEPTH_WORDS = 64
) (
	input  logic          clock,
	input  logic          reset,
	input  logic          start,
	input  rx_byte_t      uart_byte,
	input  bit_cycles_t   uart_cpd,
	input  bit_cycles_t   uart_byte_spacing,
	input  logic          rfifo_rd_en,
	output rfifo_word_t   rfifo_out,
	output rfifo_status_t rfifo_status,
	output logic          at_response_flag
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ARMED,
		S_PAD,
		S_FLAG
	} state_t;

	state_t      state;
	logic [7:0]  byte_q;
	logic        byte_wr_q;
	logic        odd_q;
	logic        seen_q;
	bit_cycles_t cycle_count;
	bit_cycles_t idle_bits;
	logic        reply_done;
	logic        pad_wr;
	logic [7:0]  fifo_wr_byte;
	logic        fifo_wr_en;

	// line quiet for the full spacing since the last byte.
	assign reply_done = seen_q && !uart_byte.valid && !uart_byte.collecting
		&& (idle_bits == uart_byte_spacing);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= S_IDLE;
			byte_wr_q   <= 1'b0;
			odd_q       <= 1'b0;
			seen_q      <= 1'b0;
			cycle_count <= '0;
			idle_bits   <= '0;
		end else begin
			byte_wr_q <= 1'b0;
			case (state)
				S_IDLE: begin
					odd_q       <= 1'b0;
					seen_q      <= 1'b0;
					cycle_count <= '0;
					idle_bits   <= '0;
					if (start)
						state <= S_ARMED;
				end
				S_ARMED: begin
					if (uart_byte.valid) begin
						byte_wr_q   <= 1'b1;
						odd_q       <= ~odd_q;
						seen_q      <= 1'b1;
						cycle_count <= '0;
						idle_bits   <= '0;
					end else if (reply_done) begin
						state <= S_PAD;
					end else if (seen_q && !uart_byte.collecting) begin
						// timer held while a frame is on the line.
						if (cycle_count == uart_cpd - 1'b1) begin
							cycle_count <= '0;
							idle_bits   <= idle_bits + 1'b1;
						end else begin
							cycle_count <= cycle_count + 1'b1;
						end
					end
				end
				S_PAD: state <= S_FLAG;
				S_FLAG: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (uart_byte.valid)
			byte_q <= uart_byte.data;
	end

	// pad write only lands when a byte is left without a partner.
	assign pad_wr       = (state == S_PAD) & odd_q;
	assign fifo_wr_en   = byte_wr_q | pad_wr;
	assign fifo_wr_byte = pad_wr ? PAD_BYTE : byte_q;

	assign at_response_flag = (state == S_FLAG);

	rx_fifo #(
		.DEPTH_WORDS(DEPTH_WORDS)
	) u_rx_fifo (
		.clock   (clock),
		.reset   (reset),
		.wr_byte (fifo_wr_byte),
		.wr_en   (fifo_wr_en),
		.rd_en   (rfifo_rd_en),
		.rd_word (rfifo_out),
		.status  (rfifo_status)
	);

endmodule

//--- verilog/handle_app_commands.sv
// commands are single bytes; only CMD_SELECT takes an operand, which must follow within the gap.
`timescale 1ns/1ns

module handle_app_commands import ble_rx_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        start,
	input  rx_byte_t    uart_byte,
	input  bit_cycles_t uart_cpd,
	input  bit_cycles_t uart_byte_spacing,
	output logic [7:0]  stream_select,
	output logic        ds_sending_flag
);

	typedef enum logic {
		S_CMD,
		S_INDEX
	} state_t;

	state_t      state;
	bit_cycles_t cycle_count;
	bit_cycles_t gap_bits;
	logic        gap_expired;

	// gap measured as idle line time, not frame time.
	assign gap_expired = !uart_byte.collecting && (gap_bits == uart_byte_spacing);

	always_ff @(posedge clock) begin
		if (reset) begin
			state           <= S_CMD;
			stream_select   <= 8'd0;
			ds_sending_flag <= 1'b0;
			cycle_count     <= '0;
			gap_bits        <= '0;
		end else if (!start) begin
			// AT mode, outputs hold.
			state <= S_CMD;
		end else begin
			case (state)
				S_CMD: begin
					if (uart_byte.valid) begin
						case (uart_byte.data)
							CMD_GO:   ds_sending_flag <= 1'b1;
							CMD_HALT: ds_sending_flag <= 1'b0;
							CMD_SELECT: begin
								state       <= S_INDEX;
								cycle_count <= '0;
								gap_bits    <= '0;
							end
							// unknown codes fall through.
							default: ;
						endcase
					end
				end
				S_INDEX: begin
					if (uart_byte.valid) begin
						stream_select <= uart_byte.data;
						state         <= S_CMD;
					end else if (gap_expired) begin
						// index too late, frame dropped.
						state <= S_CMD;
					end else if (!uart_byte.collecting) begin
						if (cycle_count == uart_cpd - 1'b1) begin
							cycle_count <= '0;
							gap_bits    <= gap_bits + 1'b1;
						end else begin
							cycle_count <= cycle_count + 1'b1;
						end
					end
				end
			endcase
		end
	end

	// a pending select never waits past the gap.
	assert property (@(posedge clock) disable iff (reset)
		(state == S_INDEX) |-> (gap_bits <= uart_byte_spacing));

endmodule

//--- verilog/receiver_centre.sv
// receive side only; RFIFO_DEPTH_WORDS may be 16, 32 or 64, and uart_cpd must be at least 4.
`timescale 1ns/1ns

module receiver_centre import ble_rx_pkg::*; #(
	parameter int RFIFO_DEPTH_WORDS = 64
) (
	input  logic          clock,
	input  logic          reset,
	input  logic          fpga_rxd,
	input  logic          want_at,
	input  logic          at_command_sent,
	input  bit_cycles_t   uart_cpd,
	input  bit_cycles_t   uart_byte_spacing,
	input  logic          rfifo_rd_en,
	output rfifo_word_t   rfifo_out,
	output rfifo_status_t rfifo_status,
	output logic          at_response_flag,
	output logic [7:0]    stream_select,
	output logic          ds_sending_flag
);

	logic     at_start;
	logic     ds_start;
	rx_byte_t rx_byte;

	// mode selects which handler listens.
	assign at_start = want_at & at_command_sent;
	assign ds_start = ~want_at & ~reset;

	uart_rx u_uart_rx (
		.clock              (clock),
		.reset              (reset),
		.rx_line            (fpga_rxd),
		.cycles_per_databit (uart_cpd),
		.rx_byte            (rx_byte)
	);

	handle_at_response #(
		.DEPTH_WORDS(RFIFO_DEPTH_WORDS)
	) u_at_handler (
		.clock             (clock),
		.reset             (reset),
		.start             (at_start),
		.uart_byte         (rx_byte),
		.uart_cpd          (uart_cpd),
		.uart_byte_spacing (uart_byte_spacing),
		.rfifo_rd_en       (rfifo_rd_en),
		.rfifo_out         (rfifo_out),
		.rfifo_status      (rfifo_status),
		.at_response_flag  (at_response_flag)
	);

	handle_app_commands u_app_handler (
		.clock             (clock),
		.reset             (reset),
		.start             (ds_start),
		.uart_byte         (rx_byte),
		.uart_cpd          (uart_cpd),
		.uart_byte_spacing (uart_byte_spacing),
		.stream_select     (stream_select),
		.ds_sending_flag   (ds_sending_flag)
	);

endmodule

//--- test/receiver_checker.sv
// reads the expected row from the testbench top receiver_centre_tb; samples on the rising edge.
`timescale 1ns/1ns

module receiver_checker import ble_rx_pkg::*; (
	input logic          clock,
	input logic          reset,
	input logic [1:0]    check_kind,
	input rfifo_word_t   rfifo_out,
	input rfifo_status_t rfifo_status,
	input logic          at_response_flag,
	input logic [7:0]    stream_select,
	input logic          ds_sending_flag
);

	localparam logic [1:0] CHK_STATUS = 2'd1;
	localparam logic [1:0] CHK_WORD   = 2'd2;
	localparam logic [1:0] CHK_END    = 2'd3;

	int mismatches = 0;
	int test_mismatches = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int flag_count = 0;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
			mismatches++;
			test_mismatches++;
		end
	endtask

	always @(posedge clock) begin
		// flag pulses counted per test.
		if (!reset && at_response_flag)
			flag_count++;
		case (check_kind)
			CHK_STATUS: begin
				compare("rfifo_status.wr_count", receiver_centre_tb.exp_wr_count,
					rfifo_status.wr_count);
				compare("rfifo_status.rd_count", receiver_centre_tb.exp_rd_count,
					rfifo_status.rd_count);
				compare("rfifo_status.full", receiver_centre_tb.exp_full, rfifo_status.full);
			end
			CHK_WORD: compare("rfifo_out", receiver_centre_tb.exp_word, rfifo_out);
			CHK_END: begin
				compare("rfifo_status.empty", 1, rfifo_status.empty);
				compare("at_response_flag pulses", receiver_centre_tb.exp_flag, flag_count);
				compare("stream_select", receiver_centre_tb.exp_stream, stream_select);
				compare("ds_sending_flag", receiver_centre_tb.exp_sending, ds_sending_flag);
				tests_run++;
				if (test_mismatches == 0) begin
					$display("test %0d ok", receiver_centre_tb.test_idx);
				end else begin
					$display("test %0d had %0d mismatches", receiver_centre_tb.test_idx,
						test_mismatches);
					tests_failed++;
				end
				test_mismatches = 0;
				flag_count = 0;
			end
			default: ;
		endcase
	end

	task automatic report();
		$display("tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, mismatches);
	endtask

endmodule

//--- test/receiver_centre_tb.sv
// fixed at uart_cpd 8 and a 4 bit-time gap; the FIFO is built with 16 words so the overflow case stays short.
`timescale 1ns/1ns

module receiver_centre_tb import ble_rx_pkg::*; ();

	localparam int DEPTH_WORDS = 16;
	localparam int CAP_BYTES   = DEPTH_WORDS * 2;
	localparam int N_TESTS     = 8;
	localparam int MAX_BYTES   = 34;
	localparam int CPD         = 8;
	localparam int SPACING     = 4;
	localparam int SETTLE      = (SPACING + 2) * CPD;
	localparam logic [1:0] CHK_NONE   = 2'd0;
	localparam logic [1:0] CHK_STATUS = 2'd1;
	localparam logic [1:0] CHK_WORD   = 2'd2;
	localparam logic [1:0] CHK_END    = 2'd3;

	logic          clock;
	logic          reset;
	logic          fpga_rxd;
	logic          want_at;
	logic          at_command_sent;
	logic          rfifo_rd_en;
	rfifo_word_t   rfifo_out;
	rfifo_status_t rfifo_status;
	logic          at_response_flag;
	logic [7:0]    stream_select;
	logic          ds_sending_flag;
	logic [1:0]    check_kind;

	// stimulus table, one entry per test.
	bit         row_want_at [N_TESTS];
	bit         row_armed [N_TESTS];
	int         row_len [N_TESTS];
	int         row_gap [N_TESTS];
	logic [7:0] row_bytes [N_TESTS][MAX_BYTES];
	bit         row_flag [N_TESTS];
	logic [7:0] row_stream [N_TESTS];
	bit         row_sending [N_TESTS];
	int         n_rows = 0;

	// expected values of the running test, read by the checker.
	int          test_idx;
	int          exp_wr_count;
	int          exp_rd_count;
	bit          exp_full;
	bit          exp_flag;
	logic [7:0]  exp_stream;
	bit          exp_sending;
	logic [15:0] exp_word;

	integer seed = 32'h7ce4_02b2;
	int     limit = 0;
	int     cycles = 0;
	bit     table_ready = 1'b0;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	receiver_centre #(
		.RFIFO_DEPTH_WORDS(DEPTH_WORDS)
	) u_receiver_centre (
		.clock             (clock),
		.reset             (reset),
		.fpga_rxd          (fpga_rxd),
		.want_at           (want_at),
		.at_command_sent   (at_command_sent),
		.uart_cpd          (10'(CPD)),
		.uart_byte_spacing (10'(SPACING)),
		.rfifo_rd_en       (rfifo_rd_en),
		.rfifo_out         (rfifo_out),
		.rfifo_status      (rfifo_status),
		.at_response_flag  (at_response_flag),
		.stream_select     (stream_select),
		.ds_sending_flag   (ds_sending_flag)
	);

	receiver_checker u_receiver_checker (
		.clock            (clock),
		.reset            (reset),
		.check_kind       (check_kind),
		.rfifo_out        (rfifo_out),
		.rfifo_status     (rfifo_status),
		.at_response_flag (at_response_flag),
		.stream_select    (stream_select),
		.ds_sending_flag  (ds_sending_flag)
	);

	// inputs change 2 ns after the rising edge.
	task automatic step(input int n);
		repeat (n) @(posedge clock);
		#2;
	endtask

	task automatic add_row(input bit want, input bit armed, input int len,
		input logic [31:0] bytes, input int gap, input bit flag,
		input logic [7:0] stream, input bit sending);
		row_want_at[n_rows] = want;
		row_armed[n_rows]   = armed;
		row_len[n_rows]     = len;
		row_gap[n_rows]     = gap;
		row_flag[n_rows]    = flag;
		row_stream[n_rows]  = stream;
		row_sending[n_rows] = sending;
		for (int i = 0; i < 4; i++)
			row_bytes[n_rows][i] = bytes[31 - 8 * i -: 8];
		n_rows++;
	endtask

	// 8N1 frame, lsb first, then gap bit times of idle line.
	task automatic send_byte(input logic [7:0] b, input int gap);
		fpga_rxd = 1'b0;
		step(CPD);
		for (int i = 0; i < 8; i++) begin
			fpga_rxd = b[i];
			step(CPD);
		end
		fpga_rxd = 1'b1;
		step(CPD * (1 + gap));
	endtask

	// bytes kept by the FIFO, odd replies padded, capped at capacity.
	function automatic int stored_bytes(input int t);
		int n;
		if (!row_armed[t])
			return 0;
		n = row_len[t] + row_len[t] % 2;
		return (n > CAP_BYTES) ? CAP_BYTES : n;
	endfunction

	function automatic logic [15:0] word_at(input int t, input int k);
		logic [7:0] low;
		low = (2 * k + 1 < row_len[t]) ? row_bytes[t][2 * k + 1] : PAD_BYTE;
		return {row_bytes[t][2 * k], low};
	endfunction

	task automatic run_test(input int t);
		test_idx     = t;
		exp_wr_count = stored_bytes(t);
		exp_rd_count = exp_wr_count / 2;
		exp_full     = (exp_wr_count == CAP_BYTES);
		exp_flag     = row_flag[t];
		exp_stream   = row_stream[t];
		exp_sending  = row_sending[t];
		want_at         = row_want_at[t];
		at_command_sent = row_armed[t];
		step(1);
		at_command_sent = 1'b0;
		for (int i = 0; i < row_len[t]; i++)
			send_byte(row_bytes[t][i], row_gap[t]);
		if (row_flag[t]) begin
			while (!at_response_flag)
				step(1);
			step(1);
		end else begin
			step(SETTLE);
		end
		check_kind = CHK_STATUS;
		step(1);
		check_kind = CHK_NONE;
		for (int k = 0; k < exp_rd_count; k++) begin
			rfifo_rd_en = 1'b1;
			step(1);
			rfifo_rd_en = 1'b0;
			exp_word   = word_at(t, k);
			check_kind = CHK_WORD;
			step(1);
			check_kind = CHK_NONE;
		end
		check_kind = CHK_END;
		step(1);
		check_kind = CHK_NONE;
	endtask

	initial begin
		reset           = 1'b1;
		fpga_rxd        = 1'b1;
		want_at         = 1'b0;
		at_command_sent = 1'b0;
		rfifo_rd_en     = 1'b0;
		check_kind      = CHK_NONE;
		test_idx        = 0;
		// want_at, armed, length, bytes, gap, flag, stream, sending.
		add_row(1, 1, 4, 32'h4f4b0d0a, 1, 1, 8'h00, 0);
		add_row(1, 1, 3, 32'h41540d00, 1, 1, 8'h00, 0);
		add_row(1, 1, 34, 32'h0, 1, 1, 8'h00, 0);
		add_row(0, 0, 2, 32'h53050000, 1, 0, 8'h05, 0);
		add_row(0, 0, 2, 32'h53090000, 6, 0, 8'h05, 0);
		add_row(0, 0, 2, 32'h473c0000, 1, 0, 8'h05, 1);
		add_row(1, 0, 3, 32'h53074800, 1, 0, 8'h05, 1);
		add_row(0, 0, 1, 32'h48000000, 1, 0, 8'h05, 0);
		// overflow reply is random filler.
		for (int i = 0; i < MAX_BYTES; i++)
			row_bytes[2][i] = 8'($random(seed));
		limit = 20;
		for (int t = 0; t < N_TESTS; t++)
			limit += row_len[t] * (10 + row_gap[t]) * CPD + 200;
		table_ready = 1'b1;
		step(4);
		reset = 1'b0;
		step(2);
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		u_receiver_checker.report();
		if (u_receiver_checker.mismatches == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		wait (table_ready);
		while (cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- files.f
verilog/ble_rx_pkg.sv
verilog/uart_rx.sv
verilog/rx_fifo.sv
verilog/handle_at_response.sv
verilog/handle_app_commands.sv
verilog/receiver_centre.sv
test/receiver_checker.sv
test/receiver_centre_tb.sv
